/* dv/cluster_patterns.txt */
# P word_addr instr | A pc dp_addr block_idx group_id | F flush | D group_id
# S addr data, data is block index + 5 - 9 for the first program, + 256 - 9 after the rewrite
P 0000 10000005
P 0001 1000fff7
P 0002 20020000
P 0003 00000000
P 0004 f0000000
S 000102 ffffffff
S 000202 0000000c
S 000302 0000003c
S 000402 fffffffc
D a1
D a2
D a3
D a4
A 0000 000100 03 a1
A 0000 000200 10 a2
A 0000 000300 40 a3
A 0000 000400 00 a4
P 0000 10000100
P 0002 20200000
F
S 000520 000000fe
D b5
A 0000 000500 07 b5

/* filelist.f */
common/cluster_pkg.sv
hdl/warp_table.sv
icache/icache.sv
hdl/warp_exec.sv
hdl/done_fifo.sv
hdl/compute_cluster.sv
dv/tb_compute_cluster.sv

/* dv/tb_compute_cluster.sv */
// Self-checking testbench for the compute cluster
// Replays dv/cluster_patterns.txt against an imem model and a data memory sink
`timescale 1ns/1ps
`default_nettype none

module tb_compute_cluster;

    logic         clk_i;
    logic         rst_n_i;
    logic         flush_ic_i;
    logic         warp_free_o;
    logic         allocate_warp_i;
    logic [15:0]  allocate_pc_i;
    logic [23:0]  allocate_dp_addr_i;
    logic [7:0]   allocate_tblock_idx_i;
    logic [7:0]   allocate_tgroup_id_i;
    logic         tblock_done_o;
    logic [7:0]   tblock_done_id_o;
    logic         tblock_done_ready_i;
    logic         imem_ar_valid_o;
    logic [15:0]  imem_ar_addr_o;
    logic         imem_ar_ready_i;
    logic         imem_r_valid_i;
    logic [127:0] imem_r_data_i;
    logic         imem_r_ready_o;
    logic         mem_aw_valid_o;
    logic [23:0]  mem_aw_addr_o;
    logic [31:0]  mem_w_data_o;
    logic         mem_aw_ready_i;

    logic [31:0]  imem [0:255];
    logic [31:0]  exp_store [int];
    int           exp_done [int];
    int           line_reqs [int];
    int           flush_lines [$];
    logic [31:0]  lfsr_q;
    logic         hold_imem;
    int           im_state;
    logic [7:0]   im_addr;
    logic [7:0]   im_wait;
    int           wd_cycles;
    int           n_checks;
    int           n_errors;
    int           alloc_count;
    logic         aw_stalled;
    logic [23:0]  aw_addr_held;
    logic [31:0]  aw_data_held;
    logic         done_stalled;
    logic [7:0]   done_id_held;

    compute_cluster DUT (.*);

    always #5 clk_i = ~clk_i;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_fields(input logic [7:0] kind, input int got, input int want);
        if (got != want) begin
            n_errors++;
            $display("%0t ns: pattern record %c has %0d fields where %0d are needed",
                     $time, kind, got, want);
        end
    endtask

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[6:0], lfsr_q[0]};
        end
    endtask

    task automatic allocate_block(input logic [31:0] pc, input logic [31:0] dp,
                                  input logic [31:0] idx, input logic [31:0] gid);
        logic accepted;
        accepted = 1'b0;
        @(posedge clk_i);
        allocate_warp_i       <= 1'b1;
        allocate_pc_i         <= pc[15:0];
        allocate_dp_addr_i    <= dp[23:0];
        allocate_tblock_idx_i <= idx[7:0];
        allocate_tgroup_id_i  <= gid[7:0];
        while (!accepted) begin
            @(negedge clk_i);
            accepted = warp_free_o;
            @(posedge clk_i);
        end
        allocate_warp_i <= 1'b0;
        alloc_count++;
    endtask

    // Returns once every expected store and done id has been seen
    task automatic wait_drain();
        while (exp_store.size() != 0 || exp_done.size() != 0) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
    endtask

    task automatic pulse_flush();
        @(posedge clk_i);
        flush_ic_i <= 1'b1;
        @(posedge clk_i);
        flush_ic_i <= 1'b0;
    endtask

    // Random ready levels and the imem read slave, drawing from the LFSR in a fixed order
    always @(posedge clk_i) begin
        logic [7:0] r;
        if (rst_n_i) begin
            draw_bits(1, r);
            mem_aw_ready_i <= r[0];
            draw_bits(1, r);
            tblock_done_ready_i <= r[0];
            case (im_state)
                0: begin
                    if (imem_ar_valid_o && !hold_imem) begin
                        imem_ar_ready_i <= 1'b1;
                        im_state = 1;
                    end
                end
                1: begin
                    // Address handshake completes on this edge
                    imem_ar_ready_i <= 1'b0;
                    im_addr = imem_ar_addr_o[7:0];
                    if (line_reqs.exists(int'(imem_ar_addr_o))) begin
                        line_reqs[int'(imem_ar_addr_o)]++;
                    end
                    draw_bits(2, im_wait);
                    im_state = 2;
                end
                2: begin
                    if (im_wait == 0) begin
                        imem_r_valid_i <= 1'b1;
                        imem_r_data_i  <= {imem[im_addr + 8'd3], imem[im_addr + 8'd2],
                                           imem[im_addr + 8'd1], imem[im_addr]};
                        im_state = 3;
                    end else begin
                        im_wait--;
                    end
                end
                default: begin
                    if (imem_r_ready_o) begin
                        imem_r_valid_i <= 1'b0;
                        im_state = 0;
                    end
                end
            endcase
        end
    end

    // Data memory sink takes each expected address once
    always @(negedge clk_i) begin
        if (rst_n_i && mem_aw_valid_o) begin
            if (aw_stalled) begin
                compare("mem_aw_addr_o", aw_addr_held, mem_aw_addr_o);
                compare("mem_w_data_o", aw_data_held, mem_w_data_o);
            end
            if (mem_aw_ready_i) begin
                if (exp_store.exists(int'(mem_aw_addr_o))) begin
                    compare("mem_w_data_o", exp_store[int'(mem_aw_addr_o)], mem_w_data_o);
                    exp_store.delete(int'(mem_aw_addr_o));
                end else begin
                    n_errors++;
                    $display("%0t ns: store to address %0h was not expected or came twice",
                             $time, mem_aw_addr_o);
                end
            end
        end
        aw_stalled   = rst_n_i && mem_aw_valid_o && !mem_aw_ready_i;
        aw_addr_held = mem_aw_addr_o;
        aw_data_held = mem_w_data_o;
    end

    always @(negedge clk_i) begin
        if (rst_n_i && tblock_done_o) begin
            if (done_stalled) begin
                compare("tblock_done_id_o", done_id_held, tblock_done_id_o);
            end
            if (tblock_done_ready_i) begin
                if (exp_done.exists(int'(tblock_done_id_o))) begin
                    exp_done.delete(int'(tblock_done_id_o));
                end else begin
                    n_errors++;
                    $display("%0t ns: group id %0h was reported done without being expected",
                             $time, tblock_done_id_o);
                end
            end
        end
        done_stalled = rst_n_i && tblock_done_o && !tblock_done_ready_i;
        done_id_held = tblock_done_id_o;
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", wd_cycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        int                fd;
        int                code;
        int                records;
        logic [7:0]        kind;
        logic [8*128-1:0]  line_buf;
        logic [31:0]       f0;
        logic [31:0]       f1;
        logic [31:0]       f2;
        logic [31:0]       f3;
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        flush_ic_i = 1'b0;
        allocate_warp_i = 1'b0;
        allocate_pc_i = '0;
        allocate_dp_addr_i = '0;
        allocate_tblock_idx_i = '0;
        allocate_tgroup_id_i = '0;
        tblock_done_ready_i = 1'b0;
        imem_ar_ready_i = 1'b0;
        imem_r_valid_i = 1'b0;
        imem_r_data_i = '0;
        mem_aw_ready_i = 1'b0;
        lfsr_q = 32'h7adf;
        hold_imem = 1'b1;
        im_state = 0;
        im_wait = '0;
        wd_cycles = 0;
        n_checks = 0;
        n_errors = 0;
        alloc_count = 0;
        aw_stalled = 1'b0;
        done_stalled = 1'b0;
        records = 0;
        // Unwritten words decode as no-ops
        for (int i = 0; i < 256; i++) begin
            imem[i] = {24'h00005a, i[7:0]};
        end

        fd = $fopen("dv/cluster_patterns.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("Could not open the pattern file dv/cluster_patterns.txt");
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                if (kind != "#") begin
                    records++;
                end
                code = $fgets(line_buf, fd);
            end
            $fclose(fd);
            wd_cycles = 200 * records + 20;
            fd = $fopen("dv/cluster_patterns.txt", "r");
        end

        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        compare("imem_ar_valid_o", 0, imem_ar_valid_o);
        compare("mem_aw_valid_o", 0, mem_aw_valid_o);
        compare("tblock_done_o", 0, tblock_done_o);
        compare("warp_free_o", 1, warp_free_o);

        while (fd != 0 && $fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "P": begin
                    code = $fscanf(fd, " %h %h", f0, f1);
                    check_fields(kind, code, 2);
                    wait_drain();
                    imem[f0[7:0]] = f1;
                    // A rewrite after blocks have run must be refetched after the flush
                    if (alloc_count > 0 && !line_reqs.exists(int'(f0 & ~32'd3))) begin
                        line_reqs[int'(f0 & ~32'd3)] = 0;
                        flush_lines.push_back(int'(f0 & ~32'd3));
                    end
                end
                "A": begin
                    code = $fscanf(fd, " %h %h %h %h", f0, f1, f2, f3);
                    check_fields(kind, code, 4);
                    allocate_block(f0, f1, f2, f3);
                    if (alloc_count == 4) begin
                        @(negedge clk_i);
                        compare("warp_free_o", 0, warp_free_o);
                        hold_imem = 1'b0;
                        while (!warp_free_o) begin
                            @(negedge clk_i);
                        end
                        // First exit frees its slot and queues its id on the same edge
                        compare("tblock_done_o", 1, tblock_done_o);
                    end
                end
                "F": begin
                    wait_drain();
                    pulse_flush();
                end
                "S": begin
                    code = $fscanf(fd, " %h %h", f0, f1);
                    check_fields(kind, code, 2);
                    exp_store[int'(f0)] = f1;
                end
                "D": begin
                    code = $fscanf(fd, " %h", f0);
                    check_fields(kind, code, 1);
                    exp_done[int'(f0)] = 1;
                end
                default: begin
                    code = $fgets(line_buf, fd);
                end
            endcase
        end
        wait_drain();
        foreach (flush_lines[i]) begin
            compare("imem_ar_addr_o refetch", 1, line_reqs[flush_lines[i]] > 0);
        end

        $display("Checks: %0d  Errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/compute_cluster.sv */
// Top level of the compute cluster
// Ties the warp table, executor, instruction cache and done queue to the outside ports
`timescale 1ns/1ps
`default_nettype none

module compute_cluster
    import cluster_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_ic_i,
    // Thread block allocation
    output logic                    warp_free_o,
    input  logic                    allocate_warp_i,
    input  logic [PC_W-1:0]         allocate_pc_i,
    input  logic [ADDR_W-1:0]       allocate_dp_addr_i,
    input  logic [TBLOCK_IDX_W-1:0] allocate_tblock_idx_i,
    input  logic [TGROUP_ID_W-1:0]  allocate_tgroup_id_i,
    // Thread block completion
    output logic                    tblock_done_o,
    output logic [TGROUP_ID_W-1:0]  tblock_done_id_o,
    input  logic                    tblock_done_ready_i,
    // Instruction memory read
    output logic                    imem_ar_valid_o,
    output logic [PC_W-1:0]         imem_ar_addr_o,
    input  logic                    imem_ar_ready_i,
    input  logic                    imem_r_valid_i,
    input  logic [LINE_W-1:0]       imem_r_data_i,
    output logic                    imem_r_ready_o,
    // Data memory write
    output logic                    mem_aw_valid_o,
    output logic [ADDR_W-1:0]       mem_aw_addr_o,
    output logic [DATA_W-1:0]       mem_w_data_o,
    input  logic                    mem_aw_ready_i
);

    logic                   issue_valid;
    logic [PC_W-1:0]        issue_pc;
    logic [DATA_W-1:0]      issue_acc;
    logic [ADDR_W-1:0]      issue_dp_addr;
    logic [TGROUP_ID_W-1:0] issue_tgroup_id;
    logic                   fetch_valid;
    logic [PC_W-1:0]        fetch_pc;
    logic                   fetch_hit;
    logic [INSTR_W-1:0]     fetch_instr;
    logic                   retire_valid;
    logic [PC_W-1:0]        retire_next_pc;
    logic [DATA_W-1:0]      retire_acc;
    logic                   retire_exit;
    logic                   push_valid;
    logic [TGROUP_ID_W-1:0] push_id;
    logic                   push_ready;

    // Warp index stays internal, the executor works on the picked state alone
    warp_table i_warp_table (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .allocate_warp_i      (allocate_warp_i),
        .allocate_pc_i        (allocate_pc_i),
        .allocate_dp_addr_i   (allocate_dp_addr_i),
        .allocate_tblock_idx_i(allocate_tblock_idx_i),
        .allocate_tgroup_id_i (allocate_tgroup_id_i),
        .warp_free_o          (warp_free_o),
        .issue_valid_o        (issue_valid),
        .issue_warp_o         (),
        .issue_pc_o           (issue_pc),
        .issue_acc_o          (issue_acc),
        .issue_dp_addr_o      (issue_dp_addr),
        .issue_tgroup_id_o    (issue_tgroup_id),
        .retire_valid_i       (retire_valid),
        .retire_next_pc_i     (retire_next_pc),
        .retire_acc_i         (retire_acc),
        .retire_exit_i        (retire_exit)
    );

    warp_exec i_warp_exec (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .issue_valid_i    (issue_valid),
        .issue_pc_i       (issue_pc),
        .issue_acc_i      (issue_acc),
        .issue_dp_addr_i  (issue_dp_addr),
        .issue_tgroup_id_i(issue_tgroup_id),
        .fetch_valid_o    (fetch_valid),
        .fetch_pc_o       (fetch_pc),
        .fetch_hit_i      (fetch_hit),
        .fetch_instr_i    (fetch_instr),
        .mem_aw_valid_o   (mem_aw_valid_o),
        .mem_aw_addr_o    (mem_aw_addr_o),
        .mem_w_data_o     (mem_w_data_o),
        .mem_aw_ready_i   (mem_aw_ready_i),
        .push_valid_o     (push_valid),
        .push_id_o        (push_id),
        .push_ready_i     (push_ready),
        .retire_valid_o   (retire_valid),
        .retire_next_pc_o (retire_next_pc),
        .retire_acc_o     (retire_acc),
        .retire_exit_o    (retire_exit)
    );

    icache i_icache (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_ic_i     (flush_ic_i),
        .fetch_valid_i  (fetch_valid),
        .fetch_pc_i     (fetch_pc),
        .fetch_hit_o    (fetch_hit),
        .fetch_instr_o  (fetch_instr),
        .imem_ar_valid_o(imem_ar_valid_o),
        .imem_ar_addr_o (imem_ar_addr_o),
        .imem_ar_ready_i(imem_ar_ready_i),
        .imem_r_valid_i (imem_r_valid_i),
        .imem_r_data_i  (imem_r_data_i),
        .imem_r_ready_o (imem_r_ready_o)
    );

    done_fifo i_done_fifo (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .push_valid_i       (push_valid),
        .push_id_i          (push_id),
        .push_ready_o       (push_ready),
        .tblock_done_o      (tblock_done_o),
        .tblock_done_id_o   (tblock_done_id_o),
        .tblock_done_ready_i(tblock_done_ready_i)
    );

endmodule

`default_nettype wire

/* hdl/done_fifo.sv */
// Two-entry queue of finished group ids in front of the block-done port
`timescale 1ns/1ps
`default_nettype none

module done_fifo
    import cluster_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   push_valid_i,
    input  logic [TGROUP_ID_W-1:0] push_id_i,
    output logic                   push_ready_o,
    output logic                   tblock_done_o,
    output logic [TGROUP_ID_W-1:0] tblock_done_id_o,
    input  logic                   tblock_done_ready_i
);

    logic [TGROUP_ID_W-1:0] mem_q [2];
    logic                   wr_ptr_q;
    logic                   rd_ptr_q;
    logic [1:0]             count_q;
    logic                   push;
    logic                   pop;

    assign push_ready_o     = (count_q != 2'd2);
    assign tblock_done_o    = (count_q != 2'd0);
    assign tblock_done_id_o = mem_q[rd_ptr_q];

    assign push = push_valid_i & push_ready_o;
    assign pop  = tblock_done_o & tblock_done_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            wr_ptr_q <= wr_ptr_q ^ push;
            rd_ptr_q <= rd_ptr_q ^ pop;
            count_q  <= count_q + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_id_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/warp_exec.sv */
// Shared decoder and executor for the picked warp
// Drives stores and done pushes, retires once the side effect is taken
`timescale 1ns/1ps
`default_nettype none

module warp_exec
    import cluster_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Picked warp
    input  logic                   issue_valid_i,
    input  logic [PC_W-1:0]        issue_pc_i,
    input  logic [DATA_W-1:0]      issue_acc_i,
    input  logic [ADDR_W-1:0]      issue_dp_addr_i,
    input  logic [TGROUP_ID_W-1:0] issue_tgroup_id_i,
    // Instruction fetch
    output logic                   fetch_valid_o,
    output logic [PC_W-1:0]        fetch_pc_o,
    input  logic                   fetch_hit_i,
    input  logic [INSTR_W-1:0]     fetch_instr_i,
    // Data memory write
    output logic                   mem_aw_valid_o,
    output logic [ADDR_W-1:0]      mem_aw_addr_o,
    output logic [DATA_W-1:0]      mem_w_data_o,
    input  logic                   mem_aw_ready_i,
    // Finished block toward the done queue
    output logic                   push_valid_o,
    output logic [TGROUP_ID_W-1:0] push_id_o,
    input  logic                   push_ready_i,
    // New warp state
    output logic                   retire_valid_o,
    output logic [PC_W-1:0]        retire_next_pc_o,
    output logic [DATA_W-1:0]      retire_acc_o,
    output logic                   retire_exit_o
);

    instr_u             instr;
    logic [INSTR_W-1:0] held_q;
    logic               pend_q;
    logic               exec;
    logic               is_addi;
    logic               is_store;
    logic               is_exit;
    logic               side_fx;

    // A stalled store or exit keeps its word, so a flush cannot drop a raised valid
    assign fetch_valid_o = issue_valid_i & ~pend_q;
    assign fetch_pc_o    = issue_pc_i;
    assign instr         = pend_q ? held_q : fetch_instr_i;
    assign exec          = issue_valid_i & (pend_q | fetch_hit_i);

    assign is_addi  = (instr.arith.opcode == OP_ADDI);
    assign is_store = (instr.store.opcode == OP_STORE);
    assign is_exit  = (instr.arith.opcode == OP_EXIT);
    assign side_fx  = exec & (is_store | is_exit);

    assign mem_aw_valid_o = exec & is_store;
    assign mem_aw_addr_o  = issue_dp_addr_i + ADDR_W'(instr.store.offset);
    assign mem_w_data_o   = issue_acc_i;

    assign push_valid_o = exec & is_exit;
    assign push_id_o    = issue_tgroup_id_i;

    always_comb begin
        retire_valid_o = exec;
        if (is_store) begin
            retire_valid_o = exec & mem_aw_ready_i;
        end else if (is_exit) begin
            retire_valid_o = exec & push_ready_i;
        end
    end

    // Immediate is sign extended onto the accumulator
    assign retire_next_pc_o = issue_pc_i + 1'b1;
    assign retire_acc_o     = is_addi ? issue_acc_i + DATA_W'(instr.arith.imm) : issue_acc_i;
    assign retire_exit_o    = is_exit;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q <= 1'b0;
        end else if (retire_valid_o) begin
            pend_q <= 1'b0;
        end else if (side_fx) begin
            pend_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (side_fx && !pend_q) begin
            held_q <= fetch_instr_i;
        end
    end

endmodule

`default_nettype wire

/* icache/icache.sv */
// Direct-mapped instruction cache, one line fill at a time over the imem read port
// Hits answer in the same cycle, flush_ic_i drops every line
`timescale 1ns/1ps
`default_nettype none

module icache
    import cluster_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               flush_ic_i,
    // Fetch side
    input  logic               fetch_valid_i,
    input  logic [PC_W-1:0]    fetch_pc_i,
    output logic               fetch_hit_o,
    output logic [INSTR_W-1:0] fetch_instr_o,
    // Instruction memory read address
    output logic               imem_ar_valid_o,
    output logic [PC_W-1:0]    imem_ar_addr_o,
    input  logic               imem_ar_ready_i,
    // Instruction memory read data, one full line
    input  logic               imem_r_valid_i,
    input  logic [LINE_W-1:0]  imem_r_data_i,
    output logic               imem_r_ready_o
);

    logic [NUM_LINES-1:0]     valid_q;
    logic [IC_TAG_W-1:0]      tag_q  [NUM_LINES];
    logic [LINE_W-1:0]        line_q [NUM_LINES];
    logic [1:0]               state_q;
    logic [PC_W-1:0]          miss_pc_q;
    logic                     fill_keep_q;
    logic [IC_WORD_IDX_W-1:0] fetch_word;
    logic [IC_LINE_IDX_W-1:0] fetch_line;
    logic [IC_TAG_W-1:0]      fetch_tag;
    logic [IC_LINE_IDX_W-1:0] fill_line;
    logic                     miss;
    logic                     fill_done;

    // pc splits into tag, line index and word within the line
    assign fetch_word = fetch_pc_i[IC_WORD_IDX_W-1:0];
    assign fetch_line = fetch_pc_i[IC_WORD_IDX_W +: IC_LINE_IDX_W];
    assign fetch_tag  = fetch_pc_i[PC_W-1 -: IC_TAG_W];
    assign fill_line  = miss_pc_q[IC_WORD_IDX_W +: IC_LINE_IDX_W];

    assign fetch_hit_o   = fetch_valid_i & valid_q[fetch_line]
                         & (tag_q[fetch_line] == fetch_tag);
    assign fetch_instr_o = line_q[fetch_line][fetch_word * INSTR_W +: INSTR_W];

    assign miss      = (state_q == IC_IDLE) & fetch_valid_i & ~fetch_hit_o;
    assign fill_done = imem_r_valid_i & imem_r_ready_o;

    assign imem_ar_valid_o = (state_q == IC_REQ);
    assign imem_ar_addr_o  = miss_pc_q;
    assign imem_r_ready_o  = (state_q == IC_WAIT);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IC_IDLE;
            valid_q     <= '0;
            fill_keep_q <= 1'b0;
        end else begin
            if (flush_ic_i) begin
                valid_q     <= '0;
                // Line in flight predates the flush
                fill_keep_q <= 1'b0;
            end else if (fill_done && fill_keep_q) begin
                valid_q[fill_line] <= 1'b1;
            end

            case (state_q)
                IC_IDLE: begin
                    if (miss) begin
                        state_q     <= IC_REQ;
                        fill_keep_q <= 1'b1;
                    end
                end
                IC_REQ: begin
                    if (imem_ar_ready_i) begin
                        state_q <= IC_WAIT;
                    end
                end
                IC_WAIT: begin
                    if (fill_done) begin
                        state_q <= IC_IDLE;
                    end
                end
                default: begin
                    state_q <= IC_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (miss) begin
            miss_pc_q <= {fetch_pc_i[PC_W-1:IC_WORD_IDX_W], {IC_WORD_IDX_W{1'b0}}};
        end
        if (fill_done) begin
            line_q[fill_line] <= imem_r_data_i;
            tag_q[fill_line]  <= miss_pc_q[PC_W-1 -: IC_TAG_W];
        end
    end

endmodule

`default_nettype wire

/* hdl/warp_table.sv */
// Warp slot table of the cluster
// Places new thread blocks in free slots and picks the issuing warp round-robin
`timescale 1ns/1ps
`default_nettype none

module warp_table
    import cluster_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Block allocation
    input  logic                    allocate_warp_i,
    input  logic [PC_W-1:0]         allocate_pc_i,
    input  logic [ADDR_W-1:0]       allocate_dp_addr_i,
    input  logic [TBLOCK_IDX_W-1:0] allocate_tblock_idx_i,
    input  logic [TGROUP_ID_W-1:0]  allocate_tgroup_id_i,
    output logic                    warp_free_o,
    // Picked warp toward the executor
    output logic                    issue_valid_o,
    output logic [WARP_IDX_W-1:0]   issue_warp_o,
    output logic [PC_W-1:0]         issue_pc_o,
    output logic [DATA_W-1:0]       issue_acc_o,
    output logic [ADDR_W-1:0]       issue_dp_addr_o,
    output logic [TGROUP_ID_W-1:0]  issue_tgroup_id_o,
    // Retire from the executor
    input  logic                    retire_valid_i,
    input  logic [PC_W-1:0]         retire_next_pc_i,
    input  logic [DATA_W-1:0]       retire_acc_i,
    input  logic                    retire_exit_i
);

    logic [NUM_WARPS-1:0]   active_q;
    logic [PC_W-1:0]        pc_q      [NUM_WARPS];
    logic [DATA_W-1:0]      acc_q     [NUM_WARPS];
    logic [ADDR_W-1:0]      dp_addr_q [NUM_WARPS];
    logic [TGROUP_ID_W-1:0] gid_q     [NUM_WARPS];
    logic [WARP_IDX_W-1:0]  rr_ptr_q;
    logic [WARP_IDX_W-1:0]  pick;
    logic [WARP_IDX_W-1:0]  cand;
    logic [WARP_IDX_W-1:0]  free_slot;
    logic                   alloc;

    assign warp_free_o = ~&active_q;
    assign alloc       = allocate_warp_i & warp_free_o;

    // Lowest free slot wins
    always_comb begin
        free_slot = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (!active_q[i]) begin
                free_slot = WARP_IDX_W'(i);
            end
        end
    end

    // First active warp at or after the pointer, scanned so the nearest one is kept
    always_comb begin
        issue_valid_o = 1'b0;
        pick          = rr_ptr_q;
        cand          = rr_ptr_q;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            cand = rr_ptr_q + WARP_IDX_W'(i);
            if (active_q[cand]) begin
                issue_valid_o = 1'b1;
                pick          = cand;
            end
        end
    end

    assign issue_warp_o      = pick;
    assign issue_pc_o        = pc_q[pick];
    assign issue_acc_o       = acc_q[pick];
    assign issue_dp_addr_o   = dp_addr_q[pick];
    assign issue_tgroup_id_o = gid_q[pick];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q <= '0;
            rr_ptr_q <= '0;
        end else begin
            if (alloc) begin
                active_q[free_slot] <= 1'b1;
            end
            if (retire_valid_i) begin
                rr_ptr_q <= pick + 1'b1;
                if (retire_exit_i) begin
                    active_q[pick] <= 1'b0;
                end
            end else if (issue_valid_o) begin
                // Pin the pick so a new block cannot steal a stalled issue
                rr_ptr_q <= pick;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc) begin
            pc_q[free_slot]      <= allocate_pc_i;
            acc_q[free_slot]     <= DATA_W'(allocate_tblock_idx_i);
            dp_addr_q[free_slot] <= allocate_dp_addr_i;
            gid_q[free_slot]     <= allocate_tgroup_id_i;
        end
        if (retire_valid_i && !retire_exit_i) begin
            pc_q[pick]  <= retire_next_pc_i;
            acc_q[pick] <= retire_acc_i;
        end
    end

endmodule

`default_nettype wire

/* common/cluster_pkg.sv */
// Shared widths, opcodes and instruction layout of the compute cluster
// Imported by every RTL block of the cluster
`default_nettype none

package cluster_pkg;

    // Warp slots
    localparam int NUM_WARPS  = 4;
    localparam int WARP_IDX_W = $clog2(NUM_WARPS);

    // Datapath widths, pc and addresses count words
    localparam int PC_W         = 16;
    localparam int ADDR_W       = 24;
    localparam int DATA_W       = 32;
    localparam int TBLOCK_IDX_W = 8;
    localparam int TGROUP_ID_W  = 8;
    localparam int INSTR_W      = 32;

    // Instruction cache geometry
    localparam int LINE_WORDS    = 4;
    localparam int LINE_W        = LINE_WORDS * INSTR_W;
    localparam int NUM_LINES     = 8;
    localparam int IC_WORD_IDX_W = $clog2(LINE_WORDS);
    localparam int IC_LINE_IDX_W = $clog2(NUM_LINES);
    localparam int IC_TAG_W      = PC_W - IC_LINE_IDX_W - IC_WORD_IDX_W;

    // Miss FSM encodings
    localparam logic [1:0] IC_IDLE = 2'd0;
    localparam logic [1:0] IC_REQ  = 2'd1;
    localparam logic [1:0] IC_WAIT = 2'd2;

    // Opcodes in the top nibble, all others run as no-op
    localparam logic [3:0] OP_ADDI  = 4'd1;
    localparam logic [3:0] OP_STORE = 4'd2;
    localparam logic [3:0] OP_EXIT  = 4'd15;

    // One instruction word seen as arithmetic or as store
    typedef union packed {
        struct packed {
            logic [3:0]          opcode;
            logic [11:0]         unused;
            logic signed [15:0]  imm;
        } arith;
        struct packed {
            logic [3:0]  opcode;
            logic [11:0] offset;
            logic [15:0] unused;
        } store;
    } instr_u;

endpackage

`default_nettype wire
